// ==== Bender.yml ====
package:
  name: rv32i_decoder

sources:
  # Design, in compile order
  - files:
      - rtl/rv32i_isa_pkg.sv
      - rtl/decode_pkg.sv
      - rtl/decode_ctrl_if.sv
      - rtl/decode_ctrl.sv
      - rtl/imm_gen.sv
      - rtl/op_decode.sv
      - rtl/rv32i_decoder.sv
  # Testbench
  - target: test
    files:
      - verification/tb_clk_gen.sv
      - verification/tb_rv32i_decoder.sv

// ==== rtl/decode_ctrl.sv ====
// Source must re-present a stalled instruction next cycle; that copy is never stalled again
`timescale 1ns/1ps
`default_nettype none

module decode_ctrl (
    input  wire logic                   clk_i,
    input  wire logic                   rstn_i,
    input  wire rv32i_isa_pkg::instr_u  instr_i,
    input  wire logic                   instr_valid_i,
    output logic                        ready_o,
    output logic                        illegal_o,
    decode_ctrl_if.ctrl                 ctrl_if
);

    import rv32i_isa_pkg::*;
    import decode_pkg::*;

    logic [ICLASS_W-1:0]   iclass_w;
    logic                  reads_rs1_w;
    logic                  hazard_w;
    logic [REG_ADDR_W-1:0] prev_rd_q;     // Destination of the last valid instruction
    logic                  stall_q;       // Previous cycle stalled

    //////////////////////////////////////////////////
    // Opcode classification
    //////////////////////////////////////////////////
    always_comb begin
        case (instr_i.r.opcode)
            OPCODE_OP:    iclass_w = ICLASS_OP;
            OPCODE_OPIMM: iclass_w = ICLASS_OPIMM;
            OPCODE_LUI:   iclass_w = ICLASS_LUI;
            OPCODE_AUIPC: iclass_w = ICLASS_AUIPC;
            OPCODE_LOAD:  iclass_w = ICLASS_LOAD;
            OPCODE_STORE: iclass_w = ICLASS_STORE;
            default:      iclass_w = ICLASS_ILLEGAL;
        endcase
    end

    assign reads_rs1_w = (iclass_w == ICLASS_OP)   || (iclass_w == ICLASS_OPIMM) ||
                         (iclass_w == ICLASS_LOAD) || (iclass_w == ICLASS_STORE);

    //////////////////////////////////////////////////
    // Read-after-write hazard against prev_rd
    //////////////////////////////////////////////////
    assign hazard_w = instr_valid_i && !stall_q &&
                      ((reads_rs1_w && (instr_i.r.rs1 != '0) && (instr_i.r.rs1 == prev_rd_q)) ||
                       ((iclass_w == ICLASS_OP) && (instr_i.r.rs2 != '0) &&
                        (instr_i.r.rs2 == prev_rd_q)));

    assign ready_o = !hazard_w;           // Low only in the hazard cycle

    assign ctrl_if.accept     = instr_valid_i;
    assign ctrl_if.bubble     = hazard_w;
    assign ctrl_if.iclass     = iclass_w;
    assign ctrl_if.shift_form = (iclass_w == ICLASS_OPIMM) &&
                                ((instr_i.r.funct3 == FUNCT3_SR) ||
                                 (instr_i.r.funct3 == FUNCT3_SLL)) &&
                                ((instr_i.r.funct7 == '0) || (instr_i.r.funct7 == FUNCT7_ALT));

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            prev_rd_q <= '0;
            stall_q   <= 1'b0;
            illegal_o <= 1'b0;
        end else begin
            stall_q <= hazard_w;
            if (instr_valid_i) begin
                // Stores and illegal words write no register
                if ((iclass_w == ICLASS_STORE) || (iclass_w == ICLASS_ILLEGAL)) begin
                    prev_rd_q <= '0;
                end else begin
                    prev_rd_q <= instr_i.r.rd;
                end
                illegal_o <= (iclass_w == ICLASS_ILLEGAL);
            end
        end
    end

endmodule

`default_nettype wire

// ==== rtl/decode_ctrl_if.sv ====
// Control decisions valid in the same cycle as the presented instruction; no clock inside
`timescale 1ns/1ps
`default_nettype none

interface decode_ctrl_if;

    import decode_pkg::*;

    logic                accept;       // Instruction captured this cycle
    logic                bubble;       // Stall copy with strobes suppressed
    logic [ICLASS_W-1:0] iclass;
    logic                shift_form;   // OP-IMM shift with a legal funct7

    // Control side
    modport ctrl (
        output accept, bubble, iclass, shift_form
    );

    // Datapath side
    modport dp (
        input  accept, bubble, iclass, shift_form
    );

endinterface

`default_nettype wire

// ==== rtl/decode_pkg.sv ====
// Decoder output codes; ALU select follows {instr[30], funct3} and LSU control {store, funct3}
`default_nettype none

package decode_pkg;

    //////////////////////////////////////////////////
    // Instruction classes
    //////////////////////////////////////////////////
    localparam int ICLASS_W = 3;

    localparam logic [ICLASS_W-1:0] ICLASS_OP      = 3'd0;
    localparam logic [ICLASS_W-1:0] ICLASS_OPIMM   = 3'd1;
    localparam logic [ICLASS_W-1:0] ICLASS_LUI     = 3'd2;
    localparam logic [ICLASS_W-1:0] ICLASS_AUIPC   = 3'd3;
    localparam logic [ICLASS_W-1:0] ICLASS_LOAD    = 3'd4;
    localparam logic [ICLASS_W-1:0] ICLASS_STORE   = 3'd5;
    localparam logic [ICLASS_W-1:0] ICLASS_ILLEGAL = 3'd6;   // Includes MISC-MEM and SYSTEM

    //////////////////////////////////////////////////
    // ALU and LSU control
    //////////////////////////////////////////////////
    localparam int ALU_SEL_W = 4;                            // Alternate bit, then funct3

    localparam logic [ALU_SEL_W-1:0] ALU_OP_ADD = 4'b0000;

    localparam int LSU_CTRL_W = 4;                           // Store bit, then funct3

endpackage

`default_nettype wire

// ==== rtl/imm_gen.sv ====
// Immediate is registered on accept and held otherwise; OP and illegal words give zero
`timescale 1ns/1ps
`default_nettype none

module imm_gen (
    input  wire logic                        clk_i,
    input  wire logic                        rstn_i,
    input  wire rv32i_isa_pkg::instr_u       instr_i,
    decode_ctrl_if.dp                        dp_if,
    output logic [rv32i_isa_pkg::XLEN-1:0]   imm_o,
    output logic                             is_imm_o
);

    import rv32i_isa_pkg::*;
    import decode_pkg::*;

    logic [XLEN-1:0] imm_w;

    //////////////////////////////////////////////////
    // Format selection and extension
    //////////////////////////////////////////////////
    always_comb begin
        case (dp_if.iclass)
            ICLASS_OPIMM: begin
                if (dp_if.shift_form) begin
                    imm_w = {{(XLEN-5){1'b0}}, instr_i.i.imm11_0[4:0]};   // Unsigned shamt
                end else begin
                    imm_w = {{(XLEN-12){instr_i.i.imm11_0[11]}}, instr_i.i.imm11_0};
                end
            end
            ICLASS_LOAD:  imm_w = {{(XLEN-12){instr_i.i.imm11_0[11]}}, instr_i.i.imm11_0};
            ICLASS_STORE: imm_w = {{(XLEN-12){instr_i.s.imm11_5[6]}},
                                   instr_i.s.imm11_5, instr_i.s.imm4_0};
            ICLASS_LUI,
            ICLASS_AUIPC: imm_w = {instr_i.u.imm31_12, 12'b0};
            default:      imm_w = '0;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            imm_o    <= '0;
            is_imm_o <= 1'b0;
        end else if (dp_if.accept) begin
            imm_o    <= imm_w;
            is_imm_o <= (dp_if.iclass != ICLASS_OP);   // Only OP takes rs2 as operand B
        end
    end

endmodule

`default_nettype wire

// ==== rtl/op_decode.sv ====
// Strobes last one cycle and are dropped for stall copies; other fields hold while idle
`timescale 1ns/1ps
`default_nettype none

module op_decode (
    input  wire logic                                clk_i,
    input  wire logic                                rstn_i,
    input  wire rv32i_isa_pkg::instr_u               instr_i,
    input  wire logic [rv32i_isa_pkg::XLEN-1:0]      instr_addr_i,
    decode_ctrl_if.dp                                dp_if,
    output logic [rv32i_isa_pkg::XLEN-1:0]           instr_addr_o,
    output logic                                     use_pc_o,
    output logic [decode_pkg::ALU_SEL_W-1:0]         alu_sel_o,
    output logic [rv32i_isa_pkg::REG_ADDR_W-1:0]     alu_dest_o,
    output logic                                     alu_wb_o,
    output logic [rv32i_isa_pkg::REG_ADDR_W-1:0]     rf_addr_a_o,
    output logic [rv32i_isa_pkg::REG_ADDR_W-1:0]     rf_addr_b_o,
    output logic                                     lsu_new_o,
    output logic [decode_pkg::LSU_CTRL_W-1:0]        lsu_ctrl_o,
    output logic [rv32i_isa_pkg::REG_ADDR_W-1:0]     lsu_rd_o
);

    import rv32i_isa_pkg::*;
    import decode_pkg::*;

    logic                  is_alu_w;      // Writes rd through the ALU
    logic                  is_lsu_w;
    logic                  reads_rs1_w;
    logic                  issue_w;       // Accepted and not a stall copy
    logic [ALU_SEL_W-1:0]  alu_sel_w;

    assign is_alu_w    = (dp_if.iclass == ICLASS_OP)  || (dp_if.iclass == ICLASS_OPIMM) ||
                         (dp_if.iclass == ICLASS_LUI) || (dp_if.iclass == ICLASS_AUIPC);
    assign is_lsu_w    = (dp_if.iclass == ICLASS_LOAD) || (dp_if.iclass == ICLASS_STORE);
    assign reads_rs1_w = (dp_if.iclass == ICLASS_OP) || (dp_if.iclass == ICLASS_OPIMM) ||
                         is_lsu_w;
    assign issue_w     = dp_if.accept && !dp_if.bubble;

    //////////////////////////////////////////////////
    // ALU select
    //////////////////////////////////////////////////
    always_comb begin
        case (dp_if.iclass)
            ICLASS_OP: alu_sel_w = {instr_i.r.funct7[5], instr_i.r.funct3};
            ICLASS_OPIMM: begin
                if (dp_if.shift_form) begin
                    alu_sel_w = {instr_i.r.funct7[5], instr_i.r.funct3};   // SRAI keeps bit 30
                end else begin
                    alu_sel_w = {1'b0, instr_i.r.funct3};
                end
            end
            default: alu_sel_w = ALU_OP_ADD;   // Addresses and U-type sums
        endcase
    end

    //////////////////////////////////////////////////
    // Output registers
    //////////////////////////////////////////////////
    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            instr_addr_o <= '0;
            use_pc_o     <= 1'b0;
            alu_sel_o    <= '0;
            alu_dest_o   <= '0;
            alu_wb_o     <= 1'b0;
            rf_addr_a_o  <= '0;
            rf_addr_b_o  <= '0;
            lsu_new_o    <= 1'b0;
            lsu_ctrl_o   <= '0;
            lsu_rd_o     <= '0;
        end else begin
            // One-cycle strobes
            alu_wb_o  <= issue_w && is_alu_w;
            lsu_new_o <= issue_w && is_lsu_w;
            use_pc_o  <= dp_if.accept && (dp_if.iclass == ICLASS_AUIPC);

            if (dp_if.accept) begin
                instr_addr_o <= instr_addr_i;
                alu_sel_o    <= alu_sel_w;
                alu_dest_o   <= is_alu_w ? instr_i.r.rd : '0;
                rf_addr_a_o  <= reads_rs1_w ? instr_i.r.rs1 : '0;
                rf_addr_b_o  <= (dp_if.iclass == ICLASS_OP) ? instr_i.r.rs2 : '0;
                lsu_ctrl_o   <= is_lsu_w ?
                                {(dp_if.iclass == ICLASS_STORE), instr_i.r.funct3} : '0;
                lsu_rd_o     <= (dp_if.iclass == ICLASS_LOAD) ? instr_i.r.rd : '0;
            end
        end
    end

endmodule

`default_nettype wire

// ==== rtl/rv32i_decoder.sv ====
// RV32I OP/OP-IMM/LUI/AUIPC/LOAD/STORE only; no output back-pressure, one-cycle RAW stall
`timescale 1ns/1ps
`default_nettype none

module rv32i_decoder (
    input  wire logic                                clk_i,
    input  wire logic                                rstn_i,
    // Fetch side
    input  wire logic [rv32i_isa_pkg::XLEN-1:0]      instr_i,
    input  wire logic [rv32i_isa_pkg::XLEN-1:0]      instr_addr_i,
    input  wire logic                                instr_valid_i,
    output logic                                     ready_o,
    output logic [rv32i_isa_pkg::XLEN-1:0]           instr_addr_o,
    output logic                                     use_pc_o,
    output logic                                     illegal_o,
    // ALU and register file
    output logic [decode_pkg::ALU_SEL_W-1:0]         alu_sel_o,
    output logic [rv32i_isa_pkg::REG_ADDR_W-1:0]     alu_dest_o,
    output logic                                     alu_wb_o,
    output logic [rv32i_isa_pkg::REG_ADDR_W-1:0]     rf_addr_a_o,
    output logic [rv32i_isa_pkg::REG_ADDR_W-1:0]     rf_addr_b_o,
    output logic                                     is_imm_o,
    output logic [rv32i_isa_pkg::XLEN-1:0]           imm_o,
    // LSU
    output logic                                     lsu_new_o,
    output logic [decode_pkg::LSU_CTRL_W-1:0]        lsu_ctrl_o,
    output logic [rv32i_isa_pkg::REG_ADDR_W-1:0]     lsu_rd_o
);

    import rv32i_isa_pkg::*;

    instr_u instr_w;

    assign instr_w = instr_u'(instr_i);   // Format views of the raw word

    decode_ctrl_if u_ctrl_if ();

    decode_ctrl u_decode_ctrl (
        .clk_i         (clk_i),
        .rstn_i        (rstn_i),
        .instr_i       (instr_w),
        .instr_valid_i (instr_valid_i),
        .ready_o       (ready_o),
        .illegal_o     (illegal_o),
        .ctrl_if       (u_ctrl_if.ctrl)
    );

    imm_gen u_imm_gen (
        .clk_i    (clk_i),
        .rstn_i   (rstn_i),
        .instr_i  (instr_w),
        .dp_if    (u_ctrl_if.dp),
        .imm_o    (imm_o),
        .is_imm_o (is_imm_o)
    );

    op_decode u_op_decode (
        .clk_i        (clk_i),
        .rstn_i       (rstn_i),
        .instr_i      (instr_w),
        .instr_addr_i (instr_addr_i),
        .dp_if        (u_ctrl_if.dp),
        .instr_addr_o (instr_addr_o),
        .use_pc_o     (use_pc_o),
        .alu_sel_o    (alu_sel_o),
        .alu_dest_o   (alu_dest_o),
        .alu_wb_o     (alu_wb_o),
        .rf_addr_a_o  (rf_addr_a_o),
        .rf_addr_b_o  (rf_addr_b_o),
        .lsu_new_o    (lsu_new_o),
        .lsu_ctrl_o   (lsu_ctrl_o),
        .lsu_rd_o     (lsu_rd_o)
    );

endmodule

`default_nettype wire

// ==== rtl/rv32i_isa_pkg.sv ====
// RV32I base encodings only; compressed and extension opcodes are not described here
`default_nettype none

package rv32i_isa_pkg;

    //////////////////////////////////////////////////
    // Widths
    //////////////////////////////////////////////////
    localparam int XLEN       = 32;                 // Data and instruction word
    localparam int REG_ADDR_W = 5;                  // x0 to x31

    //////////////////////////////////////////////////
    // Major opcodes of the supported subset
    //////////////////////////////////////////////////
    localparam logic [6:0] OPCODE_OP    = 7'b0110011;
    localparam logic [6:0] OPCODE_OPIMM = 7'b0010011;
    localparam logic [6:0] OPCODE_LUI   = 7'b0110111;
    localparam logic [6:0] OPCODE_AUIPC = 7'b0010111;
    localparam logic [6:0] OPCODE_LOAD  = 7'b0000011;
    localparam logic [6:0] OPCODE_STORE = 7'b0100011;

    // Shift selection
    localparam logic [2:0] FUNCT3_SR  = 3'b101;     // SRL/SRA, SRLI/SRAI
    localparam logic [2:0] FUNCT3_SLL = 3'b001;     // SLL, SLLI
    localparam logic [6:0] FUNCT7_ALT = 7'b0100000; // SUB and SRA

    // One instruction word seen through each base format
    typedef union packed {
        struct packed {
            logic [6:0]            funct7;
            logic [REG_ADDR_W-1:0] rs2;
            logic [REG_ADDR_W-1:0] rs1;
            logic [2:0]            funct3;
            logic [REG_ADDR_W-1:0] rd;
            logic [6:0]            opcode;
        } r;
        struct packed {
            logic [11:0]           imm11_0;     // Shift amount sits in imm11_0[4:0]
            logic [REG_ADDR_W-1:0] rs1;
            logic [2:0]            funct3;
            logic [REG_ADDR_W-1:0] rd;
            logic [6:0]            opcode;
        } i;
        struct packed {
            logic [6:0]            imm11_5;
            logic [REG_ADDR_W-1:0] rs2;
            logic [REG_ADDR_W-1:0] rs1;
            logic [2:0]            funct3;
            logic [4:0]            imm4_0;      // Occupies the rd slot
            logic [6:0]            opcode;
        } s;
        struct packed {
            logic [19:0]           imm31_12;
            logic [REG_ADDR_W-1:0] rd;
            logic [6:0]            opcode;
        } u;
    } instr_u;

endpackage

`default_nettype wire

// ==== rv32i_decoder.f ====
rtl/rv32i_isa_pkg.sv
rtl/decode_pkg.sv
rtl/decode_ctrl_if.sv
rtl/decode_ctrl.sv
rtl/imm_gen.sv
rtl/op_decode.sv
rtl/rv32i_decoder.sv
verification/tb_clk_gen.sv
verification/tb_rv32i_decoder.sv

// ==== verification/tb_clk_gen.sv ====
// Free-running clock from time zero; active-low reset released on a rising edge
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen #(
    parameter int PERIOD_NS    = 8,
    parameter int RESET_CYCLES = 8
) (
    output logic clk_o,
    output logic rstn_o
);

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD_NS / 2.0) clk_o = ~clk_o;
    end

    initial begin
        rstn_o = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        rstn_o <= 1'b1;                         // Synchronous release
    end

endmodule

`default_nettype wire

// ==== verification/tb_rv32i_decoder.sv ====
// Checks at every falling edge; the source holds a word with valid high while ready_o is low
`timescale 1ns/1ps
`default_nettype none

module tb_rv32i_decoder;

    import rv32i_isa_pkg::*;
    import decode_pkg::*;

    localparam int RESET_CYCLES   = 8;
    localparam int N_ALU          = 200;
    localparam int N_MEM          = 200;
    localparam int N_HAZARD       = 400;
    localparam int N_DIRECTED     = 7;
    localparam int N_INSTR        = N_ALU + N_MEM + N_HAZARD + N_DIRECTED;
    localparam int TIMEOUT_CYCLES = RESET_CYCLES + 3 * N_INSTR + 50;
    localparam int MODE_ALU       = 0;
    localparam int MODE_MEM       = 1;
    localparam int MODE_HAZARD    = 2;

    logic clk, rstn, instr_valid, ready, use_pc, illegal, alu_wb, is_imm, lsu_new;
    logic [XLEN-1:0]       instr;
    logic [XLEN-1:0]       instr_addr;
    logic [XLEN-1:0]       addr_out;
    logic [XLEN-1:0]       imm;
    logic [ALU_SEL_W-1:0]  alu_sel;
    logic [REG_ADDR_W-1:0] alu_dest, rf_addr_a, rf_addr_b, lsu_rd;
    logic [LSU_CTRL_W-1:0] lsu_ctrl;

    // Model state and the outputs expected after the next rising edge
    logic [REG_ADDR_W-1:0] m_prev_rd = '0;
    logic                  m_stall   = 1'b0;
    logic [XLEN-1:0]       exp_addr  = '0;
    logic [XLEN-1:0]       exp_imm   = '0;
    logic [ALU_SEL_W-1:0]  exp_sel   = '0;
    logic [REG_ADDR_W-1:0] exp_dest  = '0;
    logic [REG_ADDR_W-1:0] exp_a     = '0;
    logic [REG_ADDR_W-1:0] exp_b     = '0;
    logic [REG_ADDR_W-1:0] exp_lsu_rd   = '0;
    logic [LSU_CTRL_W-1:0] exp_lsu_ctrl = '0;
    logic exp_use_pc = 1'b0, exp_illegal = 1'b0, exp_wb = 1'b0;
    logic exp_lsu_new = 1'b0, exp_is_imm = 1'b0;

    logic [31:0]     lfsr_state;
    logic [XLEN-1:0] pc = 32'h0000_1000;
    logic            last_ready = 1'b1;
    int err_count   = 0;
    int check_count = 0;
    int stall_seen  = 0;
    int cycle_count = 0;

    tb_clk_gen #(
        .PERIOD_NS    (8),
        .RESET_CYCLES (RESET_CYCLES)
    ) u_clk_gen (
        .clk_o  (clk),
        .rstn_o (rstn)
    );

    rv32i_decoder u_rv32i_decoder (
        .clk_i (clk), .rstn_i (rstn),
        .instr_i (instr), .instr_addr_i (instr_addr), .instr_valid_i (instr_valid),
        .ready_o (ready), .instr_addr_o (addr_out), .use_pc_o (use_pc), .illegal_o (illegal),
        .alu_sel_o (alu_sel), .alu_dest_o (alu_dest), .alu_wb_o (alu_wb),
        .rf_addr_a_o (rf_addr_a), .rf_addr_b_o (rf_addr_b), .is_imm_o (is_imm), .imm_o (imm),
        .lsu_new_o (lsu_new), .lsu_ctrl_o (lsu_ctrl), .lsu_rd_o (lsu_rd)
    );

    //////////////////////////////////////////////////
    // Random source with polynomial x^32 + x^22 + x^2 + x + 1
    //////////////////////////////////////////////////
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] val;
        val = '0;
        for (int k = 0; k < n; k++) begin
            lfsr_state = lfsr_next(lfsr_state);
            val        = {val[30:0], lfsr_state[0]};
        end
        return val;
    endfunction

    //////////////////////////////////////////////////
    // Reference decode
    //////////////////////////////////////////////////
    function automatic logic [ICLASS_W-1:0] class_of(input logic [6:0] opc);
        case (opc)
            OPCODE_OP:    return ICLASS_OP;
            OPCODE_OPIMM: return ICLASS_OPIMM;
            OPCODE_LUI:   return ICLASS_LUI;
            OPCODE_AUIPC: return ICLASS_AUIPC;
            OPCODE_LOAD:  return ICLASS_LOAD;
            OPCODE_STORE: return ICLASS_STORE;
            default:      return ICLASS_ILLEGAL;
        endcase
    endfunction

    function automatic logic shift_form_of(input logic [ICLASS_W-1:0] cls, input logic [31:0] w);
        return (cls == ICLASS_OPIMM) && (w[14:12] == 3'b101 || w[14:12] == 3'b001) &&
               (w[31:25] == 7'b0000000 || w[31:25] == 7'b0100000);
    endfunction

    function automatic logic [XLEN-1:0] imm_of(input logic [ICLASS_W-1:0] cls,
                                               input logic [31:0] w);
        case (cls)
            ICLASS_OPIMM: return shift_form_of(cls, w) ? {27'b0, w[24:20]} : {{20{w[31]}}, w[31:20]};
            ICLASS_LOAD:  return {{20{w[31]}}, w[31:20]};
            ICLASS_STORE: return {{20{w[31]}}, w[31:25], w[11:7]};
            ICLASS_LUI,
            ICLASS_AUIPC: return {w[31:12], 12'h000};
            default:      return '0;
        endcase
    endfunction

    function automatic logic [ALU_SEL_W-1:0] alu_sel_of(input logic [ICLASS_W-1:0] cls,
                                                        input logic [31:0] w);
        if (cls == ICLASS_OP || shift_form_of(cls, w)) begin
            return {w[30], w[14:12]};
        end else if (cls == ICLASS_OPIMM) begin
            return {1'b0, w[14:12]};
        end
        return 4'b0000;                         // Add for addresses and U-type
    endfunction

    function automatic logic [XLEN-1:0] mk_word(input logic [6:0] f7, input logic [4:0] rs2,
                                                input logic [4:0] rs1, input logic [2:0] f3,
                                                input logic [4:0] rd, input logic [6:0] opc);
        return {f7, rs2, rs1, f3, rd, opc};
    endfunction

    function automatic logic [XLEN-1:0] gen_instr(input int mode);
        logic [31:0]     r;
        logic [6:0]      opc;
        logic [XLEN-1:0] w;
        if (mode == MODE_MEM) begin
            r   = rand_bits(1);
            opc = r[0] ? OPCODE_STORE : OPCODE_LOAD;
        end else if (mode == MODE_ALU) begin
            r   = rand_bits(3);
            opc = (r < 3) ? OPCODE_OP : (r < 6) ? OPCODE_OPIMM : r[0] ? OPCODE_AUIPC : OPCODE_LUI;
        end else begin
            r = rand_bits(5);
            if (r < 3) begin                    // About one word in ten is illegal
                r   = rand_bits(5);
                opc = {r[4:0], 2'b11};
                if (class_of(opc) != ICLASS_ILLEGAL) begin
                    opc[6] = ~opc[6];           // Lands on an unsupported major opcode
                end
            end else begin
                case (r % 6)
                    0:       opc = OPCODE_OP;
                    1:       opc = OPCODE_OPIMM;
                    2:       opc = OPCODE_LUI;
                    3:       opc = OPCODE_AUIPC;
                    4:       opc = OPCODE_LOAD;
                    default: opc = OPCODE_STORE;
                endcase
            end
        end
        r = rand_bits(25);
        w = {r[24:0], opc};
        if (mode == MODE_HAZARD) begin
            r        = rand_bits(6);            // x0 to x3 only
            w[11:7]  = {3'b000, r[1:0]};
            w[19:15] = {3'b000, r[3:2]};
            w[24:20] = {3'b000, r[5:4]};
        end
        if (opc == OPCODE_OP) begin
            r        = rand_bits(1);
            w[31:25] = r[0] ? FUNCT7_ALT : 7'h00;
        end else if (opc == OPCODE_OPIMM && (w[14:12] == FUNCT3_SR || w[14:12] == FUNCT3_SLL)) begin
            r = rand_bits(2);                   // Odd funct7 kept one time in two
            if (r == 0) begin
                w[31:25] = 7'h00;
            end else if (r == 1) begin
                w[31:25] = FUNCT7_ALT;
            end
        end
        return w;
    endfunction

    //////////////////////////////////////////////////
    // Compare tasks
    //////////////////////////////////////////////////
    task automatic report_value(input string name, input logic [XLEN-1:0] act, exp);
        err_count++;
        $display("error %s: got 0x%0h, expected 0x%0h at cycle %0d", name, act, exp, cycle_count);
    endtask

    task automatic check_ready(input logic act, input logic exp);
        check_count++;
        if (act !== exp) report_value("ready_o", act, exp);
    endtask

    task automatic check_flag(input string name, input logic act, input logic exp);
        check_count++;
        if (act !== exp) report_value(name, act, exp);
    endtask

    task automatic check_imm(input string name, input logic [XLEN-1:0] act, exp);
        check_count++;
        if (act !== exp) report_value(name, act, exp);
    endtask

    task automatic check_alu(input logic [ALU_SEL_W-1:0] sel_act, sel_exp,
                             input logic [REG_ADDR_W-1:0] dest_act, dest_exp,
                             input logic [REG_ADDR_W-1:0] a_act, a_exp, b_act, b_exp);
        check_count += 4;
        if (sel_act !== sel_exp) report_value("alu_sel_o", sel_act, sel_exp);
        if (dest_act !== dest_exp) report_value("alu_dest_o", dest_act, dest_exp);
        if (a_act !== a_exp) report_value("rf_addr_a_o", a_act, a_exp);
        if (b_act !== b_exp) report_value("rf_addr_b_o", b_act, b_exp);
    endtask

    task automatic check_lsu(input logic [LSU_CTRL_W-1:0] ctrl_act, ctrl_exp,
                             input logic [REG_ADDR_W-1:0] rd_act, rd_exp);
        check_count += 2;
        if (ctrl_act !== ctrl_exp) report_value("lsu_ctrl_o", ctrl_act, ctrl_exp);
        if (rd_act !== rd_exp) report_value("lsu_rd_o", rd_act, rd_exp);
    endtask

    //////////////////////////////////////////////////
    // One clock cycle of stimulus, check and model update
    //////////////////////////////////////////////////
    task automatic cycle_step(input logic valid, input logic [XLEN-1:0] word, addr);
        logic [ICLASS_W-1:0] cls;
        logic                rd1, is_alu, is_lsu, hazard;
        @(posedge clk);
        instr_valid <= valid;
        instr       <= word;
        instr_addr  <= addr;
        @(negedge clk);
        check_imm("instr_addr_o", addr_out, exp_addr);
        check_imm("imm_o", imm, exp_imm);
        check_alu(alu_sel, exp_sel, alu_dest, exp_dest, rf_addr_a, exp_a, rf_addr_b, exp_b);
        check_lsu(lsu_ctrl, exp_lsu_ctrl, lsu_rd, exp_lsu_rd);
        check_flag("use_pc_o", use_pc, exp_use_pc);
        check_flag("illegal_o", illegal, exp_illegal);
        check_flag("alu_wb_o", alu_wb, exp_wb);
        check_flag("lsu_new_o", lsu_new, exp_lsu_new);
        check_flag("is_imm_o", is_imm, exp_is_imm);
        cls    = class_of(word[6:0]);
        is_alu = (cls == ICLASS_OP) || (cls == ICLASS_OPIMM) ||
                 (cls == ICLASS_LUI) || (cls == ICLASS_AUIPC);
        is_lsu = (cls == ICLASS_LOAD) || (cls == ICLASS_STORE);
        rd1    = (cls == ICLASS_OP) || (cls == ICLASS_OPIMM) || is_lsu;
        hazard = valid && !m_stall &&
                 ((rd1 && word[19:15] != 0 && word[19:15] == m_prev_rd) ||
                  (cls == ICLASS_OP && word[24:20] != 0 && word[24:20] == m_prev_rd));
        check_ready(ready, !hazard);
        last_ready = ready;
        if (ready !== 1'b1) stall_seen++;
        exp_wb      = valid && !hazard && is_alu;
        exp_lsu_new = valid && !hazard && is_lsu;
        exp_use_pc  = valid && (cls == ICLASS_AUIPC);
        if (valid) begin
            exp_addr     = addr;
            exp_illegal  = (cls == ICLASS_ILLEGAL);
            exp_sel      = alu_sel_of(cls, word);
            exp_dest     = is_alu ? word[11:7] : '0;
            exp_a        = rd1 ? word[19:15] : '0;
            exp_b        = (cls == ICLASS_OP) ? word[24:20] : '0;
            exp_lsu_ctrl = is_lsu ? {(cls == ICLASS_STORE), word[14:12]} : '0;
            exp_lsu_rd   = (cls == ICLASS_LOAD) ? word[11:7] : '0;
            exp_imm      = imm_of(cls, word);
            exp_is_imm   = (cls != ICLASS_OP);
            m_prev_rd    = (cls == ICLASS_STORE || cls == ICLASS_ILLEGAL) ? '0 : word[11:7];
        end
        m_stall = hazard;
    endtask

    task automatic issue(input logic [XLEN-1:0] word);
        cycle_step(1'b1, word, pc);
        while (last_ready !== 1'b1) begin
            cycle_step(1'b1, word, pc);         // Same word again after a stall
        end
        pc = pc + 4;
    endtask

    task automatic report_test(input string name, input int n, stalls, errs);
        $display("test %s: %0d instructions, %0d stalls, %0d errors", name, n, stalls, errs);
    endtask

    task automatic run_random(input string name, input int mode, input int count);
        int errs_before;
        int stalls_before;
        errs_before   = err_count;
        stalls_before = stall_seen;
        for (int k = 0; k < count; k++) begin
            if (rand_bits(3) == 0) cycle_step(1'b0, rand_bits(32), rand_bits(32));
            issue(gen_instr(mode));
        end
        report_test(name, count, stall_seen - stalls_before, err_count - errs_before);
    endtask

    task automatic run_store_then_read();
        int errs_before;
        int stalls;
        errs_before = err_count;
        stalls      = stall_seen;
        issue(mk_word(7'h00, 5'd0, 5'd0, 3'b000, 5'd0, OPCODE_LUI));       // prev_rd back to x0
        issue(mk_word(7'h00, 5'd2, 5'd1, 3'b010, 5'd5, OPCODE_STORE));     // SW with 5 in rd slot
        issue(mk_word(7'h00, 5'd5, 5'd5, 3'b000, 5'd8, OPCODE_OP));
        issue(mk_word(7'h00, 5'd0, 5'd9, 3'b010, 5'd6, OPCODE_LOAD));
        issue(mk_word(7'h00, 5'd3, 5'd6, 3'b000, 5'd10, OPCODE_OPIMM));    // Reads x6 and stalls
        issue(mk_word(7'h00, 5'd0, 5'd0, 3'b000, 5'd7, 7'b1110011));       // SYSTEM
        issue(mk_word(FUNCT7_ALT, 5'd7, 5'd1, 3'b000, 5'd11, OPCODE_OP));
        cycle_step(1'b0, '0, '0);               // Outputs of the last word
        stalls = stall_seen - stalls;
        if (stalls != 1) begin
            err_count++;
            $display("store_then_read: ready_o dropped %0d times where one stall belongs", stalls);
        end
        report_test("store_then_read", N_DIRECTED, stalls, err_count - errs_before);
    endtask

    // Watchdog
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

    initial begin
        int errs_before;
        instr       = '0;
        instr_addr  = '0;
        instr_valid = 1'b0;
        lfsr_state  = 32'h41735800;
        wait (rstn === 1'b1);
        errs_before = err_count;
        repeat (4) cycle_step(1'b0, rand_bits(32), rand_bits(32));   // Outputs idle at zero
        report_test("reset_idle", 0, 0, err_count - errs_before);
        run_random("alu_ops", MODE_ALU, N_ALU);
        run_random("mem_ops", MODE_MEM, N_MEM);
        run_random("hazard_mix", MODE_HAZARD, N_HAZARD);
        run_store_then_read();
        $display("summary: 5 tests, %0d checks, %0d errors", check_count, err_count);
        if (err_count == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire
